// ==== cdc_bridge_top.sv ====
`timescale 1ns/1ps

module cdc_bridge_top (
  input  logic                        i_wclk,
  input  logic                        i_rclk,
  input  logic                        i_rst_n,
  // wishbone side in the i_wclk domain
  input  logic                        i_wb_cyc,
  input  logic                        i_wb_stb,
  input  logic                        i_wb_we,
  input  logic [wb_pkg::WB_ADR_W-1:0] i_wb_adr,
  input  logic [cdc_pkg::DATA_W-1:0]  i_wb_dat,
  output logic [cdc_pkg::DATA_W-1:0]  o_wb_dat,
  output logic                        o_wb_ack,
  // stream side in the i_rclk domain
  output logic [cdc_pkg::DATA_W-1:0]  o_rdata,
  output logic                        o_rvalid,
  input  logic                        i_rready
);

  import cdc_pkg::*;

  logic               push;
  logic [DATA_W-1:0]  push_data;
  logic               full;
  logic               empty_w;
  logic [LEVEL_W-1:0] wlevel;  // write-domain fill count

  wb_fifo_port u_port (
    .i_wclk      (i_wclk),
    .i_rst_n     (i_rst_n),
    .i_wb_cyc    (i_wb_cyc),
    .i_wb_stb    (i_wb_stb),
    .i_wb_we     (i_wb_we),
    .i_wb_adr    (i_wb_adr),
    .i_wb_dat    (i_wb_dat),
    .o_wb_dat    (o_wb_dat),
    .o_wb_ack    (o_wb_ack),
    .o_push      (push),
    .o_push_data (push_data),
    .i_full      (full),
    .i_empty     (empty_w),
    .i_level     (wlevel)
  );

  cdc_fifo u_fifo (
    .i_wclk      (i_wclk),
    .i_rclk      (i_rclk),
    .i_rst_n     (i_rst_n),
    .i_push      (push),
    .i_push_data (push_data),
    .o_full      (full),
    .o_empty_w   (empty_w),
    .o_wlevel    (wlevel),
    .o_rdata     (o_rdata),
    .o_rvalid    (o_rvalid),
    .i_rready    (i_rready)
  );

endmodule

// ==== cdc_fifo.sv ====
`timescale 1ns/1ps

module cdc_fifo (
  input  logic                        i_wclk,
  input  logic                        i_rclk,
  input  logic                        i_rst_n,
  // write domain
  input  logic                        i_push,
  input  logic [cdc_pkg::DATA_W-1:0]  i_push_data,
  output logic                        o_full,
  output logic                        o_empty_w,
  output logic [cdc_pkg::LEVEL_W-1:0] o_wlevel,
  // read domain
  output logic [cdc_pkg::DATA_W-1:0]  o_rdata,
  output logic                        o_rvalid,
  input  logic                        i_rready
);

  import cdc_pkg::*;

  logic [DATA_W-1:0]  mem [FIFO_DEPTH];

  logic [LEVEL_W-1:0] wgray_q;       // write pointer in i_wclk
  logic [LEVEL_W-1:0] wbin;
  logic [LEVEL_W-1:0] rgray_sync_w;  // read pointer seen in i_wclk
  logic [LEVEL_W-1:0] rbin_sync_w;
  logic               push_ok;

  logic [LEVEL_W-1:0] rgray_q;       // read pointer in i_rclk
  logic [LEVEL_W-1:0] rbin;
  logic [LEVEL_W-1:0] wgray_sync_r;  // write pointer seen in i_rclk
  logic               pop;

  // write side
  assign wbin        = to_bin(wgray_q);
  assign rbin_sync_w = to_bin(rgray_sync_w);
  assign push_ok     = i_push && !o_full;  // never overwrite unread data

  // same slot on the opposite lap
  assign o_full    = (wbin[PTR_W-1:0] == rbin_sync_w[PTR_W-1:0]) &&
                     (wgray_q[PTR_W] != rgray_sync_w[PTR_W]);
  assign o_empty_w = (wgray_q == rgray_sync_w);
  assign o_wlevel  = wbin - rbin_sync_w;  // lags pops by the sync delay

  always_ff @(posedge i_wclk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      wgray_q <= '0;
    end else if (push_ok) begin
      wgray_q <= to_gray(wbin + 1'b1);
    end
  end

  always_ff @(posedge i_wclk) begin
    if (push_ok) begin
      mem[wbin[PTR_W-1:0]] <= i_push_data;
    end
  end

  // read side
  assign rbin     = to_bin(rgray_q);
  assign o_rvalid = (rgray_q != wgray_sync_r);  // not empty
  assign pop      = o_rvalid && i_rready;
  assign o_rdata  = mem[rbin[PTR_W-1:0]];       // head word read without latency

  always_ff @(posedge i_rclk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      rgray_q <= '0;
    end else if (pop) begin
      rgray_q <= to_gray(rbin + 1'b1);
    end
  end

  // pointer crossings
  ptr_sync u_wptr_sync (
    .i_clk   (i_rclk),
    .i_rst_n (i_rst_n),
    .i_gray  (wgray_q),
    .o_gray  (wgray_sync_r)
  );

  ptr_sync u_rptr_sync (
    .i_clk   (i_wclk),
    .i_rst_n (i_rst_n),
    .i_gray  (rgray_q),
    .o_gray  (rgray_sync_w)
  );

endmodule

// ==== cdc_pkg.sv ====
package cdc_pkg;

  // depth must stay a power of two
  localparam int FIFO_DEPTH = 8;
  localparam int PTR_W      = $clog2(FIFO_DEPTH);  // address bits
  localparam int DATA_W     = 32;
  localparam int LEVEL_W    = PTR_W + 1;           // address bits plus wrap bit

  // binary to reflected gray code
  function automatic logic [LEVEL_W-1:0] to_gray(
    input logic [LEVEL_W-1:0] bin
  );
    logic [LEVEL_W-1:0] g;
    g = bin ^ (bin >> 1);
    return g;
  endfunction

  // gray back to binary from the msb down
  function automatic logic [LEVEL_W-1:0] to_bin(
    input logic [LEVEL_W-1:0] gray
  );
    logic [LEVEL_W-1:0] b;
    b[LEVEL_W-1] = gray[LEVEL_W-1];  // msb is shared
    for (int i = LEVEL_W - 2; i >= 0; i--) begin
      b[i] = b[i+1] ^ gray[i];
    end
    return b;
  endfunction

endpackage

// ==== ptr_sync.sv ====
`timescale 1ns/1ps

module ptr_sync (
  input  logic                        i_clk,
  input  logic                        i_rst_n,
  input  logic [cdc_pkg::LEVEL_W-1:0] i_gray,
  output logic [cdc_pkg::LEVEL_W-1:0] o_gray
);

  import cdc_pkg::*;

  // first stage may go metastable and the second settles it
  // gray input moves one bit per step so o_gray is always old or new
  logic [LEVEL_W-1:0] meta_q;

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      meta_q <= '0;
      o_gray <= '0;
    end else begin
      meta_q <= i_gray;  // stage 1
      o_gray <= meta_q;  // stage 2
    end
  end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# build the testbench with Verilator, run it and look for the pass message

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --top-module tb_cdc_bridge -f sources.f -o tb_cdc_bridge; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/tb_cdc_bridge)
status=$?
echo "$out"

if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -q "^sim passed$"; then
  exit 0
fi

echo "pass message not found in simulation output"
exit 1

// ==== sources.f ====
cdc_pkg.sv
wb_pkg.sv
ptr_sync.sv
cdc_fifo.sv
wb_fifo_port.sv
cdc_bridge_top.sv
tb_clk_gen.sv
tb_cdc_bridge.sv

// ==== tb_cdc_bridge.sv ====
`timescale 1ns/1ps

module tb_cdc_bridge;

  import cdc_pkg::*;
  import wb_pkg::*;

  localparam logic [31:0] SEED = 32'h3b49_0e66;
  localparam int ACK_LIMIT   = 16;   // wclk cycles one access may wait
  localparam int DRAIN_LIMIT = 200;  // wclk cycles for the stream to drain
  localparam int POLL_LIMIT  = 10;   // status polls before giving up on empty
  localparam int HOLD_CYCLES = 30;   // stalled write with the reader off
  localparam int N_ACCESS    = 100;
  localparam int N_DRAIN     = 5;
  localparam realtime WATCHDOG_NS =
    (N_ACCESS * (ACK_LIMIT + 2) + N_DRAIN * DRAIN_LIMIT + HOLD_CYCLES + 40) * 20.0;

  logic               i_wclk;
  logic               i_rclk;
  logic               i_rst_n;
  logic               i_wb_cyc;
  logic               i_wb_stb;
  logic               i_wb_we;
  logic [WB_ADR_W-1:0] i_wb_adr;
  logic [DATA_W-1:0]  i_wb_dat;
  logic [DATA_W-1:0]  o_wb_dat;
  logic               o_wb_ack;
  logic [DATA_W-1:0]  o_rdata;
  logic               o_rvalid;
  logic               i_rready;

  logic [DATA_W-1:0]  exp_q [$];  // scoreboard in push order
  logic [31:0]        data_state;
  logic [31:0]        rdy_state;
  logic               rd_en;
  logic               throttle;

  tb_clk_gen #(.HALF_PERIOD(10.0)) u_wclk_gen (.o_clk(i_wclk));
  tb_clk_gen #(.HALF_PERIOD(7.0))  u_rclk_gen (.o_clk(i_rclk));

  cdc_bridge_top dut (
    .i_wclk   (i_wclk),
    .i_rclk   (i_rclk),
    .i_rst_n  (i_rst_n),
    .i_wb_cyc (i_wb_cyc),
    .i_wb_stb (i_wb_stb),
    .i_wb_we  (i_wb_we),
    .i_wb_adr (i_wb_adr),
    .i_wb_dat (i_wb_dat),
    .o_wb_dat (o_wb_dat),
    .o_wb_ack (o_wb_ack),
    .o_rdata  (o_rdata),
    .o_rvalid (o_rvalid),
    .i_rready (i_rready)
  );

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("sim failed");
    $fatal(1);
  endtask

  task automatic check_word(input string name, input logic [DATA_W-1:0] got,
                            input logic [DATA_W-1:0] exp);
    if (got !== exp) begin
      $display("Mismatch %s: got 0x%h expected 0x%h", name, got, exp);
      report_failure("data word check failed");
    end
  endtask

  task automatic check_status(input logic [DATA_W-1:0] got, input logic [LEVEL_W-1:0] level,
                              input logic full, input logic empty);
    logic [DATA_W-1:0] exp;
    exp = '0;
    exp[STAT_LEVEL_LSB +: STAT_LEVEL_W] = level;
    exp[STAT_FULL_BIT]  = full;
    exp[STAT_EMPTY_BIT] = empty;
    if (got !== exp) begin
      $display("Mismatch o_wb_dat (status): got 0x%h expected 0x%h", got, exp);
      report_failure("status check failed");
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("Mismatch %s: got 0x%h expected 0x%h", name, got, exp);
      report_failure("flag check failed");
    end
  endtask

  // request on a rising edge and ack sampled on the falling edge
  task automatic wb_access(input logic we, input logic [WB_ADR_W-1:0] adr,
                           input logic [DATA_W-1:0] dat, output logic [DATA_W-1:0] rdata);
    @(posedge i_wclk);
    i_wb_cyc <= 1'b1;
    i_wb_stb <= 1'b1;
    i_wb_we  <= we;
    i_wb_adr <= adr;
    i_wb_dat <= dat;
    wait_ack(rdata);
    release_bus();
  endtask

  task automatic wait_ack(output logic [DATA_W-1:0] rdata);
    int n;
    n = 0;
    @(negedge i_wclk);
    while (!o_wb_ack) begin
      n++;
      if (n > ACK_LIMIT) report_failure("Wishbone access got no ack in time");
      @(negedge i_wclk);
    end
    rdata = o_wb_dat;
  endtask

  task automatic release_bus();
    @(posedge i_wclk);
    i_wb_cyc <= 1'b0;
    i_wb_stb <= 1'b0;
    i_wb_we  <= 1'b0;
  endtask

  task automatic push_word(input logic [DATA_W-1:0] w);
    logic [DATA_W-1:0] unused;
    exp_q.push_back(w);
    wb_access(1'b1, ADR_DATA, w, unused);
  endtask

  function automatic logic [DATA_W-1:0] next_word();
    data_state = lcg_next(data_state);
    return data_state;
  endfunction

  task automatic wait_drain();
    int n;
    n = 0;
    while (exp_q.size() != 0) begin
      n++;
      if (n > DRAIN_LIMIT) report_failure("stream did not deliver all written words");
      @(negedge i_wclk);
    end
  endtask

  task automatic wait_empty();
    logic [DATA_W-1:0] st;
    int n;
    n = 0;
    wb_access(1'b0, ADR_STATUS, '0, st);
    while (!st[STAT_EMPTY_BIT]) begin
      n++;
      if (n > POLL_LIMIT) report_failure("FIFO never reported empty on the write side");
      wb_access(1'b0, ADR_STATUS, '0, st);
    end
  endtask

  // reader samples pops at the falling edge where inputs are settled
  always @(negedge i_rclk) begin
    if (i_rst_n && o_rvalid && i_rready) begin
      if (exp_q.size() == 0) begin
        report_failure("stream returned a word that was never written");
      end else begin
        check_word("o_rdata", o_rdata, exp_q.pop_front());
      end
    end
  end

  always @(posedge i_rclk) begin
    rdy_state = lcg_next(rdy_state);
    i_rready <= rd_en && (!throttle || rdy_state[20]);
  end

  task automatic test_reset();
    logic [DATA_W-1:0] st;
    @(negedge i_wclk);
    check_bit("o_wb_ack", o_wb_ack, 1'b0);
    check_bit("o_rvalid", o_rvalid, 1'b0);
    check_word("o_wb_dat", o_wb_dat, '0);
    wb_access(1'b0, ADR_STATUS, '0, st);
    check_status(st, 4'd0, 1'b0, 1'b1);
  endtask

  task automatic test_in_order();
    rd_en = 1'b1;
    for (int i = 0; i < 5; i++) begin
      push_word(next_word());
    end
    wait_drain();
  endtask

  task automatic test_back_pressure();
    logic [DATA_W-1:0] st;
    logic [DATA_W-1:0] w;
    rd_en = 1'b0;
    wait_empty();
    for (int i = 0; i < FIFO_DEPTH; i++) begin
      push_word(next_word());
    end
    wb_access(1'b0, ADR_STATUS, '0, st);
    check_status(st, 4'd8, 1'b1, 1'b0);
    w = next_word();
    exp_q.push_back(w);
    @(posedge i_wclk);
    i_wb_cyc <= 1'b1;
    i_wb_stb <= 1'b1;
    i_wb_we  <= 1'b1;
    i_wb_adr <= ADR_DATA;
    i_wb_dat <= w;
    repeat (HOLD_CYCLES) begin
      @(negedge i_wclk);
      check_bit("o_wb_ack", o_wb_ack, 1'b0);  // held off while full
    end
    rd_en = 1'b1;
    wait_ack(st);
    release_bus();
    wait_drain();
  endtask

  task automatic test_throttled_stream();
    throttle = 1'b1;
    rd_en    = 1'b1;
    for (int i = 0; i < 40; i++) begin
      push_word(next_word());
    end
    wait_drain();
    throttle = 1'b0;
  endtask

  task automatic test_unmapped_access();
    logic [DATA_W-1:0] st;
    rd_en = 1'b0;
    wait_empty();
    push_word(next_word());
    push_word(next_word());
    wb_access(1'b0, ADR_STATUS, '0, st);
    check_status(st, 4'd2, 1'b0, 1'b0);
    for (int a = 1; a < 4; a++) begin
      wb_access(1'b1, WB_ADR_W'(a), next_word(), st);  // acked without a push
    end
    wb_access(1'b0, ADR_STATUS, '0, st);
    check_status(st, 4'd2, 1'b0, 1'b0);
    wb_access(1'b0, ADR_DATA, '0, st);
    check_word("o_wb_dat", st, '0);
    wb_access(1'b0, 2'd2, '0, st);
    check_word("o_wb_dat", st, '0);
    wb_access(1'b0, 2'd3, '0, st);
    check_word("o_wb_dat", st, '0);
    rd_en = 1'b1;
    wait_drain();  // exactly the two pushed words
    wait_empty();
    @(negedge i_rclk);
    check_bit("o_rvalid", o_rvalid, 1'b0);
  endtask

  initial begin
    #(WATCHDOG_NS);
    report_failure("watchdog expired before the tests finished");
  end

  initial begin
    data_state = SEED;
    rdy_state  = ~SEED;  // separate stream for the ready toggling
    rd_en      = 1'b0;
    throttle   = 1'b0;
    i_rst_n    = 1'b0;
    i_wb_cyc   = 1'b0;
    i_wb_stb   = 1'b0;
    i_wb_we    = 1'b0;
    i_wb_adr   = '0;
    i_wb_dat   = '0;
    i_rready   = 1'b0;
    repeat (4) @(posedge i_wclk);
    i_rst_n <= 1'b1;
    test_reset();
    test_in_order();
    test_back_pressure();
    test_throttled_stream();
    test_unmapped_access();
    $display("sim passed");
    $finish;
  end

endmodule

// ==== tb_clk_gen.sv ====
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter real HALF_PERIOD = 10.0  // ns
) (
  output logic o_clk
);

  initial begin
    o_clk = 1'b0;
  end

  always begin
    #(HALF_PERIOD);
    o_clk = ~o_clk;
  end

endmodule

// ==== wb_fifo_port.sv ====
`timescale 1ns/1ps

module wb_fifo_port (
  input  logic                        i_wclk,
  input  logic                        i_rst_n,
  // wishbone classic slave
  input  logic                        i_wb_cyc,
  input  logic                        i_wb_stb,
  input  logic                        i_wb_we,
  input  logic [wb_pkg::WB_ADR_W-1:0] i_wb_adr,
  input  logic [cdc_pkg::DATA_W-1:0]  i_wb_dat,
  output logic [cdc_pkg::DATA_W-1:0]  o_wb_dat,
  output logic                        o_wb_ack,
  // fifo write side
  output logic                        o_push,
  output logic [cdc_pkg::DATA_W-1:0]  o_push_data,
  input  logic                        i_full,
  input  logic                        i_empty,
  input  logic [cdc_pkg::LEVEL_W-1:0] i_level
);

  import cdc_pkg::*;
  import wb_pkg::*;

  logic              req;
  logic              data_wr;
  logic              ack_next;
  logic [DATA_W-1:0] status_word;
  logic [DATA_W-1:0] rd_word;

  // ack high means this request is done, so block a repeat
  assign req      = i_wb_cyc && i_wb_stb && !o_wb_ack;
  assign data_wr  = req && i_wb_we && (i_wb_adr == ADR_DATA);
  assign ack_next = req && !(data_wr && i_full);  // wait states while full

  // push lands on the edge that raises ack
  assign o_push      = data_wr && !i_full;
  assign o_push_data = i_wb_dat;

  always_comb begin
    status_word = '0;
    status_word[STAT_LEVEL_LSB +: STAT_LEVEL_W] = STAT_LEVEL_W'(i_level);
    status_word[STAT_FULL_BIT]  = i_full;
    status_word[STAT_EMPTY_BIT] = i_empty;
  end

  // only status is readable
  always_comb begin
    case (i_wb_adr)
      ADR_STATUS: rd_word = status_word;
      default:    rd_word = '0;
    endcase
  end

  always_ff @(posedge i_wclk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_wb_ack <= 1'b0;
      o_wb_dat <= '0;
    end else begin
      o_wb_ack <= ack_next;
      if (ack_next) begin
        o_wb_dat <= i_wb_we ? '0 : rd_word;  // writes return zero
      end
    end
  end

endmodule

// ==== wb_pkg.sv ====
package wb_pkg;

  // wishbone address width
  localparam int WB_ADR_W = 2;

  // register map
  localparam logic [WB_ADR_W-1:0] ADR_DATA   = 2'd0;  // push register
  localparam logic [WB_ADR_W-1:0] ADR_STATUS = 2'd1;  // status register

  // status word layout where unlisted bits read zero
  localparam int STAT_LEVEL_LSB = 0;
  localparam int STAT_LEVEL_W   = 4;  // bits 3:0
  localparam int STAT_FULL_BIT  = 8;
  localparam int STAT_EMPTY_BIT = 9;

endpackage
